/* ahb_slave_top.f */
+incdir+source
source/ahb_slave_pkg.sv
source/ahb_addr_phase.sv
source/ahb_sram_core.sv
source/ahb_resp_gen.sv
source/ahb_slave_top.sv
sim/ahb_slave_asserts.sv
sim/ahb_slave_tb.sv

/* sim/ahb_slave_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ahb_slave_macros.svh"

module ahb_slave_tb;

  import ahb_slave_pkg::*;

  localparam int MEM_WORDS = `AHB_MEM_WORDS;
  localparam int LIMIT     = 20;

  logic                       HCLK;
  logic                       reset;
  logic                       HSEL;
  logic [`AHB_ADDR_WIDTH-1:0] HADDR;
  htrans_t                    HTRANS;
  logic                       HWRITE;
  hsize_t                     HSIZE;
  logic [`AHB_DATA_WIDTH-1:0] HWDATA;
  logic                       HREADY;
  logic                       HREADYOUT;
  hresp_t                     HRESP;
  logic [`AHB_DATA_WIDTH-1:0] HRDATA;

  // Byte-wide reference memory
  logic [7:0] ref_mem [MEM_WORDS*4];

  // Expected response of the data phase in progress
  logic        exp_ready;
  hresp_t      exp_resp;
  logic [31:0] exp_rdata;
  logic        exp_active;
  int          err_phase;

  // Write waiting for its data phase
  logic        pend_wr;
  logic [31:0] pend_addr;
  logic [2:0]  pend_size;
  logic [31:0] data_next;

  int err_count;
  int err_mark;
  int tests_passed;
  int tests_failed;

  ahb_slave_top #(
    .MEM_WORDS (MEM_WORDS)
  ) u_dut (
    .HCLK      (HCLK),
    .reset     (reset),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .HRDATA    (HRDATA)
  );

  always #20 HCLK = ~HCLK;

  // Oversize, misaligned or past the memory
  function automatic logic addr_bad(input logic [2:0] size, input logic [31:0] addr);
    logic bad;
    bad = (size > 3'd2) || (addr >= MEM_WORDS * 4);
    if ((size == 3'd1) && addr[0]) begin
      bad = 1'b1;
    end
    if ((size == 3'd2) && (addr[1:0] != 2'b00)) begin
      bad = 1'b1;
    end
    return bad;
  endfunction

  // Little-endian byte lanes
  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [31:0] addr);
    case (size)
      3'd0:    return 4'b0001 << addr[1:0];
      3'd1:    return 4'b0011 << {addr[1], 1'b0};
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [31:0] base;
    base = addr & ~32'h3;
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  // Preload value spread over the whole index
  function automatic logic [31:0] fill_word(input int idx);
    return (idx + 1) * 32'h9E37_79B9;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("TIMEOUT at %0t: %s", $time, what);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic check_outputs;
    assert (HREADYOUT === exp_ready) else begin
      $display("MISMATCH %0t HREADYOUT exp %b got %b", $time, exp_ready, HREADYOUT);
      err_count++;
    end
    assert (HRESP === exp_resp) else begin
      $display("MISMATCH %0t HRESP exp %b got %b", $time, exp_resp, HRESP);
      err_count++;
    end
    assert (HRDATA === exp_rdata) else begin
      $display("MISMATCH %0t HRDATA exp %h got %h", $time, exp_rdata, HRDATA);
      err_count++;
    end
  endtask

  // Checks and drives at the falling edge and advances the model at the rising edge
  task automatic bus_cycle(input logic sel, input htrans_t trans, input logic write,
                           input logic [2:0] size, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic stall,
                           output logic accepted);
    logic       bad;
    logic [3:0] lanes;
    @(negedge HCLK);
    // Outputs only move at the rising edge
    check_outputs();
    HSEL   = sel;
    HTRANS = trans;
    HWRITE = write;
    HSIZE  = hsize_t'(size);
    HADDR  = addr;
    HWDATA = data_next;
    // Other slave stalls only outside our own data phase
    HREADY = (stall && !exp_active) ? 1'b0 : HREADYOUT;
    @(posedge HCLK);
    accepted = sel && HREADY && ((trans == NONSEQ) || (trans == SEQ));
    bad      = addr_bad(size, addr);
    // Write data phase ends on this edge
    if (pend_wr) begin
      lanes = lane_mask(pend_size, pend_addr);
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          ref_mem[(pend_addr & ~32'h3) + i] = HWDATA[8*i +: 8];
        end
      end
    end
    pend_wr   = accepted && !bad && write;
    pend_addr = addr;
    pend_size = size;
    data_next = wdata;
    // Two-cycle error sequence
    if (accepted && bad) begin
      err_phase = 1;
    end else if (err_phase == 1) begin
      err_phase = 2;
    end else begin
      err_phase = 0;
    end
    exp_ready  = (err_phase != 1);
    exp_resp   = (err_phase != 0) ? ERROR : OKAY;
    exp_rdata  = (accepted && !bad && !write) ? ref_word(addr) : 32'h0;
    exp_active = accepted || (err_phase == 2);
  endtask

  // Hold the address until the slave takes it
  task automatic do_transfer(input logic write, input logic [2:0] size,
                             input logic [31:0] addr, input logic [31:0] wdata);
    logic taken;
    int   tries;
    taken = 1'b0;
    tries = 0;
    while (!taken && (tries < LIMIT)) begin
      bus_cycle(1'b1, NONSEQ, write, size, addr, wdata, 1'b0, taken);
      tries++;
    end
    if (!taken) begin
      stop_on_timeout("address phase never accepted");
    end
  endtask

  task automatic idle_cycles(input int n);
    logic taken;
    repeat (n) begin
      bus_cycle(1'b1, IDLE, 1'b0, 3'd2, 32'h0, $urandom, 1'b0, taken);
    end
  endtask

  task automatic finish_test(input string name);
    int now;
    now = err_count + u_dut.u_asserts.fail_count;
    if (now == err_mark) begin
      tests_passed++;
      $display("test %-10s PASS", name);
    end else begin
      tests_failed++;
      $display("test %-10s FAIL, %0d errors", name, now - err_mark);
    end
    err_mark = now;
  endtask

  initial begin
    logic        taken;
    logic [31:0] base;
    logic [31:0] addr;
    logic [2:0]  size;
    int          r;
    int          words[3];
    void'($urandom(32'h8c56));
    HCLK       = 1'b0;
    reset      = 1'b1;
    HSEL       = 1'b0;
    HADDR      = '0;
    HTRANS     = IDLE;
    HWRITE     = 1'b0;
    HSIZE      = WORD;
    HWDATA     = '0;
    HREADY     = 1'b1;
    exp_ready  = 1'b1;
    exp_resp   = OKAY;
    exp_rdata  = '0;
    exp_active = 1'b0;
    err_phase  = 0;
    pend_wr    = 1'b0;
    pend_addr  = '0;
    pend_size  = '0;
    data_next  = '0;
    err_count  = 0;
    err_mark   = 0;
    tests_passed = 0;
    tests_failed = 0;
    words = '{5, 77, MEM_WORDS - 1};
    repeat (8) @(posedge HCLK);
    @(negedge HCLK);
    reset = 1'b0;

    // Quiet bus with IDLE, BUSY and deselected cycles
    idle_cycles(3);
    bus_cycle(1'b1, BUSY, 1'b1, 3'd2, 32'h10, $urandom, 1'b0, taken);
    bus_cycle(1'b0, NONSEQ, 1'b1, 3'd2, 32'h14, $urandom, 1'b0, taken);
    bus_cycle(1'b0, SEQ, 1'b0, 3'd2, 32'h18, $urandom, 1'b0, taken);
    idle_cycles(2);
    finish_test("reset_idle");

    // Preload every word, then read some back
    for (int w = 0; w < MEM_WORDS; w++) begin
      do_transfer(1'b1, 3'd2, w * 4, fill_word(w));
    end
    idle_cycles(2);
    for (int w = 0; w < 8; w++) begin
      do_transfer(1'b0, 3'd2, w * 4, 32'h0);
    end
    do_transfer(1'b1, 3'd2, 32'h24, 32'hCAFE_F00D);
    idle_cycles(3);
    do_transfer(1'b0, 3'd2, 32'h24, 32'h0);
    do_transfer(1'b0, 3'd2, (MEM_WORDS - 1) * 4, 32'h0);
    idle_cycles(1);
    finish_test("word_rw");

    // Each byte lane, then each halfword lane
    foreach (words[k]) begin
      base = words[k] * 4;
      for (int b = 0; b < 4; b++) begin
        do_transfer(1'b1, 3'd0, base + b, $urandom);
        idle_cycles(1);
        do_transfer(1'b0, 3'd2, base, 32'h0);
      end
      do_transfer(1'b1, 3'd1, base, $urandom);
      do_transfer(1'b1, 3'd1, base + 2, $urandom);
      idle_cycles(1);
      do_transfer(1'b0, 3'd2, base, 32'h0);
    end
    idle_cycles(1);
    finish_test("lanes");

    // Read right behind a write to the same word
    foreach (words[k]) begin
      base = words[k] * 4;
      do_transfer(1'b1, 3'd0, base + 2, $urandom);
      do_transfer(1'b0, 3'd2, base, 32'h0);
      do_transfer(1'b1, 3'd1, base + 2, $urandom);
      do_transfer(1'b0, 3'd2, base, 32'h0);
      do_transfer(1'b1, 3'd2, base, $urandom);
      do_transfer(1'b0, 3'd2, base, 32'h0);
    end
    idle_cycles(1);
    finish_test("forward");

    // Bad transfers each followed by a read of the same word
    base = 32'h40;
    do_transfer(1'b1, 3'd1, base + 1, $urandom);
    do_transfer(1'b0, 3'd2, base, 32'h0);
    do_transfer(1'b1, 3'd2, base + 2, $urandom);
    do_transfer(1'b0, 3'd2, base, 32'h0);
    do_transfer(1'b0, 3'd2, base + 1, 32'h0);
    do_transfer(1'b1, 3'd3, base, $urandom);
    do_transfer(1'b0, 3'd2, base, 32'h0);
    do_transfer(1'b0, 3'd5, base, 32'h0);
    // Back-to-back errors
    do_transfer(1'b1, 3'd2, MEM_WORDS * 4 + 8, $urandom);
    do_transfer(1'b1, 3'd0, 32'h8000_0000, $urandom);
    do_transfer(1'b0, 3'd2, 32'h8, 32'h0);
    do_transfer(1'b0, 3'd2, base, 32'h0);
    idle_cycles(3);
    finish_test("errors");

    // Mixed traffic against the reference model
    for (int n = 0; n < 300; n++) begin
      r    = $urandom_range(0, 99);
      size = $urandom_range(0, 2);
      addr = $urandom_range(0, MEM_WORDS - 1) * 4;
      if (size == 3'd0) begin
        addr = addr + $urandom_range(0, 3);
      end else if (size == 3'd1) begin
        addr = addr + 2 * $urandom_range(0, 1);
      end
      case ($urandom_range(0, 19))
        0:       size = $urandom_range(3, 7);
        1:       addr[1:0] = $urandom_range(0, 3);
        2:       addr = addr + MEM_WORDS * 4 * $urandom_range(1, 4);
        default: addr = addr;
      endcase
      if (r < 8) begin
        bus_cycle(1'b1, IDLE, $urandom_range(0, 1), size, addr, $urandom, 1'b0, taken);
      end else if (r < 12) begin
        bus_cycle(1'b1, BUSY, $urandom_range(0, 1), size, addr, $urandom, 1'b0, taken);
      end else if (r < 18) begin
        bus_cycle(1'b0, NONSEQ, $urandom_range(0, 1), size, addr, $urandom, 1'b0, taken);
      end else if (r < 26) begin
        bus_cycle(1'b1, NONSEQ, $urandom_range(0, 1), size, addr, $urandom, 1'b1, taken);
      end else begin
        bus_cycle(1'b1, $urandom_range(0, 1) ? NONSEQ : SEQ, $urandom_range(0, 1),
                  size, addr, $urandom, 1'b0, taken);
      end
    end
    idle_cycles(3);
    finish_test("random");

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/ahb_slave_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module ahb_slave_asserts (
  input wire                          HCLK,
  input wire                          reset,
  input wire                          HSEL,
  input wire ahb_slave_pkg::htrans_t  HTRANS,
  input wire                          HREADY,
  input wire                          HREADYOUT,
  input wire ahb_slave_pkg::hresp_t   HRESP
);

  import ahb_slave_pkg::*;

  // Read by the testbench after each test
  int   fail_count = 0;
  logic addr_taken;

  // Address phase seen by this slave
  assign addr_taken = HSEL && HREADY && ((HTRANS == NONSEQ) || (HTRANS == SEQ));

  // First error cycle always gives way to the second
  a_err_second: assert property (@(posedge HCLK) disable iff (reset)
    (HRESP == ERROR && !HREADYOUT) |=> (HRESP == ERROR && HREADYOUT))
    else begin
      fail_count++;
      $error("ERROR response did not complete its second cycle");
    end

  // Only one wait state per error
  a_single_wait: assert property (@(posedge HCLK) disable iff (reset)
    !HREADYOUT |=> HREADYOUT)
    else begin
      fail_count++;
      $error("HREADYOUT low for two cycles in a row");
    end

  // ERROR only right after a taken transfer or a first error cycle
  a_okay_idle: assert property (@(posedge HCLK) disable iff (reset)
    (HRESP == ERROR) |-> ($past(addr_taken) || $past(HRESP == ERROR && !HREADYOUT)))
    else begin
      fail_count++;
      $error("ERROR response without an error transfer in progress");
    end

endmodule

bind ahb_slave_top ahb_slave_asserts u_asserts (.*);

`default_nettype wire

/* source/ahb_slave_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ahb_slave_macros.svh"

module ahb_slave_top #(
  parameter int  MEM_WORDS = `AHB_MEM_WORDS,
  localparam int WORD_AW   = $clog2(MEM_WORDS)
) (
  input  wire                          HCLK,
  input  wire                          reset,
  input  wire                          HSEL,
  input  wire [`AHB_ADDR_WIDTH-1:0]    HADDR,
  input  wire ahb_slave_pkg::htrans_t  HTRANS,
  input  wire                          HWRITE,
  input  wire ahb_slave_pkg::hsize_t   HSIZE,
  input  wire [`AHB_DATA_WIDTH-1:0]    HWDATA,
  input  wire                          HREADY,
  output logic                         HREADYOUT,
  output ahb_slave_pkg::hresp_t        HRESP,
  output logic [`AHB_DATA_WIDTH-1:0]   HRDATA
);

  // Address phase to memory
  logic                       wr_pend;
  logic [WORD_AW-1:0]         wr_word;
  logic [3:0]                 wr_strb;
  logic                       rd_en;
  logic [WORD_AW-1:0]         rd_word;

  // Toward the response side
  logic                       err_start;
  logic [`AHB_DATA_WIDTH-1:0] rd_data;

  // Decode and classify
  ahb_addr_phase #(
    .MEM_WORDS (MEM_WORDS)
  ) u_addr_phase (
    .HCLK      (HCLK),
    .reset     (reset),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HREADY    (HREADY),
    .wr_pend   (wr_pend),
    .wr_word   (wr_word),
    .wr_strb   (wr_strb),
    .rd_en     (rd_en),
    .rd_word   (rd_word),
    .err_start (err_start)
  );

  // Storage with write forwarding
  ahb_sram_core #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram_core (
    .HCLK      (HCLK),
    .reset     (reset),
    .wr_pend   (wr_pend),
    .wr_word   (wr_word),
    .wr_strb   (wr_strb),
    .HWDATA    (HWDATA),
    .rd_en     (rd_en),
    .rd_word   (rd_word),
    .rd_data   (rd_data)
  );

  // HREADYOUT, HRESP, HRDATA
  ahb_resp_gen u_resp_gen (
    .HCLK      (HCLK),
    .reset     (reset),
    .err_start (err_start),
    .rd_data   (rd_data),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .HRDATA    (HRDATA)
  );

endmodule

`default_nettype wire

/* source/ahb_resp_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ahb_slave_macros.svh"

module ahb_resp_gen (
  input  wire                          HCLK,
  input  wire                          reset,
  input  wire                          err_start,
  input  wire [`AHB_DATA_WIDTH-1:0]    rd_data,
  output logic                         HREADYOUT,
  output ahb_slave_pkg::hresp_t        HRESP,
  output logic [`AHB_DATA_WIDTH-1:0]   HRDATA
);

  import ahb_slave_pkg::*;

  // Response sequencing
  typedef enum logic [1:0] {
    ST_OKAY       = 2'b00,
    ST_ERR_FIRST  = 2'b01,
    ST_ERR_SECOND = 2'b10
  } resp_state_t;

  resp_state_t state;
  resp_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_OKAY: begin
        if (err_start) begin
          state_nxt = ST_ERR_FIRST;
        end
      end
      // Bus is held here, no new address phase can land
      ST_ERR_FIRST: begin
        state_nxt = ST_ERR_SECOND;
      end
      // Next transfer may itself be an error
      ST_ERR_SECOND: begin
        state_nxt = err_start ? ST_ERR_FIRST : ST_OKAY;
      end
      default: begin
        state_nxt = ST_OKAY;
      end
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (reset) begin
      state <= ST_OKAY;
    end else begin
      state <= state_nxt;
    end
  end

  // Low only in the first error cycle
  assign HREADYOUT = (state != ST_ERR_FIRST);

  assign HRESP = (state == ST_OKAY) ? OKAY : ERROR;

  // Read data only outside an error response
  assign HRDATA = (state == ST_OKAY) ? rd_data : '0;

endmodule

`default_nettype wire

/* source/ahb_sram_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ahb_slave_macros.svh"

module ahb_sram_core #(
  parameter int  MEM_WORDS = `AHB_MEM_WORDS,
  localparam int WORD_AW   = $clog2(MEM_WORDS),
  localparam int LANES     = `AHB_DATA_WIDTH / 8
) (
  input  wire                         HCLK,
  input  wire                         reset,
  input  wire                         wr_pend,
  input  wire [WORD_AW-1:0]           wr_word,
  input  wire [LANES-1:0]             wr_strb,
  input  wire [`AHB_DATA_WIDTH-1:0]   HWDATA,
  input  wire                         rd_en,
  input  wire [WORD_AW-1:0]           rd_word,
  output logic [`AHB_DATA_WIDTH-1:0]  rd_data
);

  // Word storage
  logic [`AHB_DATA_WIDTH-1:0] mem [MEM_WORDS];

  logic [`AHB_DATA_WIDTH-1:0] rd_merged;
  logic                       fwd_hit;

  // Write in its data phase targets the word being read
  assign fwd_hit = wr_pend && (wr_word == rd_word);

  // Stored word with the in-flight write bytes laid over it
  always_comb begin
    rd_merged = mem[rd_word];
    if (fwd_hit) begin
      for (int i = 0; i < LANES; i++) begin
        if (wr_strb[i]) begin
          rd_merged[8*i +: 8] = HWDATA[8*i +: 8];
        end
      end
    end
  end

  // Commit on the edge ending the write data phase
  // HWDATA valid during that phase only
  always_ff @(posedge HCLK) begin
    if (wr_pend) begin
      for (int i = 0; i < LANES; i++) begin
        if (wr_strb[i]) begin
          mem[wr_word][8*i +: 8] <= HWDATA[8*i +: 8];
        end
      end
    end
  end

  // Read word for the next data phase
  // Zero whenever the coming phase is not a good read
  always_ff @(posedge HCLK) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= rd_merged;
    end else begin
      rd_data <= '0;
    end
  end

endmodule

`default_nettype wire

/* source/ahb_addr_phase.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ahb_slave_macros.svh"

module ahb_addr_phase #(
  parameter int  MEM_WORDS = `AHB_MEM_WORDS,
  localparam int WORD_AW   = $clog2(MEM_WORDS)
) (
  input  wire                           HCLK,
  input  wire                           reset,
  input  wire                           HSEL,
  input  wire [`AHB_ADDR_WIDTH-1:0]     HADDR,
  input  wire ahb_slave_pkg::htrans_t   HTRANS,
  input  wire                           HWRITE,
  input  wire ahb_slave_pkg::hsize_t    HSIZE,
  input  wire                           HREADY,
  output logic                          wr_pend,
  output logic [WORD_AW-1:0]            wr_word,
  output logic [3:0]                    wr_strb,
  output logic                          rd_en,
  output logic [WORD_AW-1:0]            rd_word,
  output logic                          err_start
);

  import ahb_slave_pkg::*;

  logic               accept;
  logic               size_bad;
  logic               align_bad;
  logic               range_bad;
  logic               bad;
  logic [3:0]         strb;
  logic [WORD_AW-1:0] word_idx;

  // Address phase taken only on a non-stalled bus
  assign accept = HSEL && HREADY && ((HTRANS == NONSEQ) || (HTRANS == SEQ));

  // Word index inside the memory
  assign word_idx = HADDR[WORD_AW+1:2];

  // Any set bit above the memory window is out of range
  assign range_bad = |HADDR[`AHB_ADDR_WIDTH-1:WORD_AW+2];

  // Lane decode and alignment check per size
  always_comb begin
    size_bad  = 1'b0;
    align_bad = 1'b0;
    strb      = 4'b0000;
    case (HSIZE)
      BYTE: begin
        strb = 4'b0001 << HADDR[1:0];
      end
      HALF: begin
        // Halfword must sit on an even byte
        align_bad = HADDR[0];
        strb      = HADDR[1] ? 4'b1100 : 4'b0011;
      end
      WORD: begin
        align_bad = |HADDR[1:0];
        strb      = 4'b1111;
      end
      default: begin
        // Doubleword and wider
        size_bad = 1'b1;
      end
    endcase
  end

  assign bad = size_bad || align_bad || range_bad;

  // Error response starts with the accepting edge
  assign err_start = accept && bad;

  // Reads go to the memory at the accepting edge
  assign rd_en   = accept && !bad && !HWRITE;
  assign rd_word = word_idx;

  // Write stays pending for exactly its data phase
  always_ff @(posedge HCLK) begin
    if (reset) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= accept && !bad && HWRITE;
    end
  end

  // Write target captured for the data phase
  always_ff @(posedge HCLK) begin
    if (accept && HWRITE) begin
      wr_word <= word_idx;
      wr_strb <= strb;
    end
  end

endmodule

`default_nettype wire

/* source/ahb_slave_pkg.sv */
`default_nettype none

package ahb_slave_pkg;

  // Transfer type on HTRANS
  // Only NONSEQ and SEQ carry a real access
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Transfer size on HSIZE
  // Anything above WORD is illegal for a 32-bit slave
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  // AHB-Lite response, single bit
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

endpackage

`default_nettype wire

/* source/ahb_slave_macros.svh */
`ifndef AHB_SLAVE_MACROS_SVH
`define AHB_SLAVE_MACROS_SVH

// Bus widths seen on the AHB-Lite slave port
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// Default depth of the word memory
// Any power of two from 16 to 4096 fits the decoder
`define AHB_MEM_WORDS 256

`endif
